// ==== hw/slow_ctrl_pkg.sv ====
//////////////////////////////////////////////////
// slow control shared definitions
//////////////////////////////////////////////////

package slow_ctrl_pkg;

  ////////////////////////////////////////////////
  // ipbus word and address
  localparam int IPB_DATA_W = 32;                 // ipbus data width
  localparam int IPB_ADDR_W = 24;                 // ipbus address width

  typedef logic [IPB_DATA_W-1:0] ipb_data_t;      // one data word
  typedef logic [IPB_ADDR_W-1:0] ipb_addr_t;      // one address

  ////////////////////////////////////////////////
  // address fields
  localparam int SEL_MSB = 23;                    // top nibble picks the peer
  localparam int SEL_LSB = 20;
  localparam int IDX_MSB = 3;                     // low nibble picks the register
  localparam int IDX_LSB = 0;                     // bits 19..4 are don't care

  typedef logic [SEL_MSB-SEL_LSB:0] slave_sel_t;  // peer select field
  typedef logic [IDX_MSB-IDX_LSB:0] reg_idx_t;    // register index field

  // select values, 0..4 are the channels
  localparam slave_sel_t SEL_CLK_SYNTH = 4'd5;    // adc clock synthesizer
  localparam slave_sel_t SEL_AFE_DAC   = 4'd6;    // afe dac, 7..15 reserved

  // channel register map
  localparam reg_idx_t REG_CTRL    = 4'd0;        // bit 0 is readout pause
  localparam reg_idx_t REG_SCRATCH = 4'd1;        // free read/write
  localparam reg_idx_t REG_ID      = 4'd2;        // channel number, read only

  // serial port register map
  localparam reg_idx_t REG_WORD   = 4'd0;         // programming word, write starts shift
  localparam reg_idx_t REG_STATUS = 4'd1;         // bit 0 busy

  ////////////////////////////////////////////////
  // serial programming words
  typedef logic [31:0] synth_word_t;              // clock synth word
  typedef logic [23:0] dac_word_t;                // afe dac word

endpackage

// ==== hw/ipb_io_fsm.sv ====
//////////////////////////////////////////////////
// ipbus handshake state machine
//////////////////////////////////////////////////
`timescale 1ns/10ps

module ipb_io_fsm (
  input  logic ipb_clk,      // ipbus clock
  input  logic arst_n,       // async reset, active low
  input  logic ipb_strobe,   // bus cycle request
  input  logic ipb_write,    // 1 = write, 0 = read
  input  logic io_rd_ack,    // read data ready, from arbiter
  output logic io_sync,      // operation in progress
  output logic io_rd_en,     // read operation
  output logic io_wr_en,     // one cycle write enable
  output logic ipb_ack       // one cycle ack to ipbus
);

  typedef enum logic [2:0] {
    ST_IDLE,                 // waiting for strobe
    ST_WRITE,                // fixed two cycle write
    ST_READ_WAIT,            // waiting for read ack
    ST_ACK,                  // ack pulse out
    ST_RELEASE               // wait for strobe to drop
  } state_t;

  state_t state;
  logic   wr_cnt;            // second write cycle flag

  always_ff @(posedge ipb_clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      wr_cnt   <= 1'b0;
      io_sync  <= 1'b0;
      io_rd_en <= 1'b0;
      io_wr_en <= 1'b0;
      ipb_ack  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          wr_cnt <= 1'b0;
          if (ipb_strobe) begin                   // cycle 0
            io_sync  <= 1'b1;
            io_wr_en <= ipb_write;
            io_rd_en <= ~ipb_write;
            state    <= ipb_write ? ST_WRITE : ST_READ_WAIT;
          end
        end
        ST_WRITE: begin
          io_wr_en <= 1'b0;                       // peer stored at edge 1
          wr_cnt   <= 1'b1;
          if (wr_cnt) begin                       // edge 2
            io_sync <= 1'b0;
            ipb_ack <= 1'b1;
            state   <= ST_ACK;
          end
        end
        ST_READ_WAIT: begin
          if (io_rd_ack) begin                    // data already in ipb_rdata
            io_sync  <= 1'b0;
            io_rd_en <= 1'b0;
            ipb_ack  <= 1'b1;
            state    <= ST_ACK;
          end
        end
        ST_ACK: begin
          ipb_ack <= 1'b0;                        // single cycle ack
          state   <= ST_RELEASE;
        end
        ST_RELEASE: begin
          if (!ipb_strobe) state <= ST_IDLE;      // master dropped strobe
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== hw/slave_bus_arbiter.sv ====
//////////////////////////////////////////////////
// peer select and read data arbiter
//////////////////////////////////////////////////
`timescale 1ns/10ps

module slave_bus_arbiter import slow_ctrl_pkg::*; #(
  parameter int N_CHAN = 5                        // number of channel blocks
) (
  input  logic                     ipb_clk,
  input  logic                     arst_n,
  input  slave_sel_t               slave_sel,     // top nibble of address
  input  logic                     io_sync,
  input  logic                     io_rd_en,
  output logic [N_CHAN+1:0]        io_sel,        // chans, then synth, then dac
  input  ipb_data_t [N_CHAN-1:0]   chan_rd_data,
  input  logic [N_CHAN-1:0]        chan_rd_ack,
  input  ipb_data_t                synth_rd_data,
  input  ipb_data_t                dac_rd_data,
  input  logic                     synth_rd_ack,
  input  logic                     dac_rd_ack,
  output logic                     io_rd_ack,     // to state machine
  output ipb_data_t                ipb_rdata      // read data to ipbus
);

  logic sel_reserved;        // no peer behind this select
  logic rsv_hit;             // reserved read, lines up with peer acks
  logic any_ack;             // some peer has data
  logic rd_cycle;            // read in progress

  ////////////////////////////////////////////////
  // one-hot decode of the select field
  always_comb begin
    io_sel = '0;
    for (int k = 0; k < N_CHAN; k++) begin
      io_sel[k] = (slave_sel == slave_sel_t'(k));
    end
    io_sel[N_CHAN]   = (slave_sel == SEL_CLK_SYNTH);
    io_sel[N_CHAN+1] = (slave_sel == SEL_AFE_DAC);
  end

  assign sel_reserved = ~|io_sel;
  assign rd_cycle     = io_sync & io_rd_en;
  assign any_ack      = |chan_rd_ack | synth_rd_ack | dac_rd_ack | rsv_hit;

  ////////////////////////////////////////////////
  // ack combining
  always_ff @(posedge ipb_clk or negedge arst_n) begin
    if (!arst_n) begin
      rsv_hit   <= 1'b0;
      io_rd_ack <= 1'b0;
    end else begin
      rsv_hit   <= rd_cycle & sel_reserved;      // answers in place of a peer
      io_rd_ack <= rd_cycle & any_ack;           // edge 2 of a read
    end
  end

  ////////////////////////////////////////////////
  // read data steering, holds until next read
  always_ff @(posedge ipb_clk) begin
    if (rd_cycle) begin
      if (rsv_hit) ipb_rdata <= '0;              // reserved space reads zero
      for (int k = 0; k < N_CHAN; k++) begin
        if (chan_rd_ack[k]) ipb_rdata <= chan_rd_data[k];
      end
      if (synth_rd_ack) ipb_rdata <= synth_rd_data;
      if (dac_rd_ack)   ipb_rdata <= dac_rd_data;
    end
  end

endmodule

// ==== hw/chan_regs.sv ====
//////////////////////////////////////////////////
// readout channel registers
//////////////////////////////////////////////////
`timescale 1ns/10ps

module chan_regs import slow_ctrl_pkg::*; #(
  parameter int CHAN_ID = 0                       // read back on REG_ID
) (
  input  logic      ipb_clk,
  input  logic      arst_n,
  input  logic      io_sel,          // this channel addressed
  input  logic      io_sync,         // operation in progress
  input  logic      io_rd_en,        // read operation
  input  logic      io_wr_en,        // one cycle write strobe
  input  reg_idx_t  reg_idx,         // register inside the channel
  input  ipb_data_t wr_data,         // write data
  output ipb_data_t rd_data,         // registered read data
  output logic      rd_ack,          // read data valid
  output logic      readout_pause    // stop the channel sending data
);

  ipb_data_t ctrl_reg;       // control, bit 0 pause
  ipb_data_t scratch_reg;    // scratch
  logic      wr_hit;
  logic      rd_hit;

  assign wr_hit = io_sel & io_sync & io_wr_en;
  assign rd_hit = io_sel & io_sync & io_rd_en;

  ////////////////////////////////////////////////
  // writable registers
  always_ff @(posedge ipb_clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_reg    <= '0;
      scratch_reg <= '0;
    end else if (wr_hit) begin
      case (reg_idx)
        REG_CTRL:    ctrl_reg    <= wr_data;
        REG_SCRATCH: scratch_reg <= wr_data;
        default: ;                                // id and unmapped ignore writes
      endcase
    end
  end

  assign readout_pause = ctrl_reg[0];

  // ack one cycle after a selected read
  always_ff @(posedge ipb_clk or negedge arst_n) begin
    if (!arst_n) rd_ack <= 1'b0;
    else         rd_ack <= rd_hit;
  end

  // readback mux
  always_ff @(posedge ipb_clk) begin
    if (rd_hit) begin
      case (reg_idx)
        REG_CTRL:    rd_data <= ctrl_reg;
        REG_SCRATCH: rd_data <= scratch_reg;
        REG_ID:      rd_data <= ipb_data_t'(CHAN_ID);
        default:     rd_data <= '0;              // unmapped index
      endcase
    end
  end

endmodule

// ==== hw/serial_prog_port.sv ====
//////////////////////////////////////////////////
// serial programming port
//////////////////////////////////////////////////
`timescale 1ns/10ps

module serial_prog_port import slow_ctrl_pkg::*; #(
  parameter type word_t          = synth_word_t,  // programming word
  parameter int  SCLK_DIV        = 4,             // ipb_clk cycles per sclk half period
  parameter bit  FRAME_ACTIVE_LOW = 1'b0          // 1 = frame low while shifting
) (
  input  logic      ipb_clk,
  input  logic      arst_n,
  input  logic      io_sel,          // this port addressed
  input  logic      io_sync,
  input  logic      io_rd_en,
  input  logic      io_wr_en,
  input  reg_idx_t  reg_idx,
  input  ipb_data_t wr_data,
  output ipb_data_t rd_data,
  output logic      rd_ack,
  output logic      sclk,            // serial clock to chip
  output logic      sdo,             // serial data, msb first
  output logic      frame            // enable / sync level
);

  localparam int W  = $bits(word_t);              // bits per shift
  localparam int DW = $clog2(SCLK_DIV + 1);       // divider counter width
  localparam int BW = $clog2(W);                  // bit counter width

  localparam logic [DW-1:0] DIV_LAST = DW'(SCLK_DIV - 1);
  localparam logic [BW-1:0] BIT_LAST = BW'(W - 1);

  word_t           word_reg;         // last accepted word, for readback
  word_t           shift_reg;        // msb goes out on sdo
  logic            busy;             // shift in progress
  logic [DW-1:0]   div_cnt;          // half period counter
  logic [BW-1:0]   bit_cnt;          // bits already sent
  logic            half_end;         // end of an sclk half period
  logic            word_wr;          // accepted write to REG_WORD
  logic            rd_hit;

  assign word_wr  = io_sel & io_sync & io_wr_en & (reg_idx == REG_WORD) & ~busy;
  assign rd_hit   = io_sel & io_sync & io_rd_en;
  assign half_end = busy & (div_cnt == DIV_LAST);

  ////////////////////////////////////////////////
  // shift sequencer
  always_ff @(posedge ipb_clk or negedge arst_n) begin
    if (!arst_n) begin
      busy    <= 1'b0;
      sclk    <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else if (!busy) begin
      if (word_wr) begin                          // start a frame
        busy    <= 1'b1;
        div_cnt <= '0;
        bit_cnt <= '0;
        sclk    <= 1'b0;
      end
    end else if (half_end) begin
      div_cnt <= '0;
      sclk    <= ~sclk;
      if (sclk) begin                             // falling edge, next bit
        if (bit_cnt == BIT_LAST) busy <= 1'b0;    // last bit done
        else bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // word and shift payload
  always_ff @(posedge ipb_clk) begin
    if (word_wr) begin
      word_reg  <= word_t'(wr_data[W-1:0]);
      shift_reg <= word_t'(wr_data[W-1:0]);
    end else if (half_end && sclk) begin
      shift_reg <= shift_reg << 1;                // data moves on falling sclk
    end
  end

  assign sdo   = busy & shift_reg[W-1];
  assign frame = FRAME_ACTIVE_LOW ? ~busy : busy;

  ////////////////////////////////////////////////
  // register readback
  always_ff @(posedge ipb_clk or negedge arst_n) begin
    if (!arst_n) rd_ack <= 1'b0;
    else         rd_ack <= rd_hit;
  end

  always_ff @(posedge ipb_clk) begin
    if (rd_hit) begin
      case (reg_idx)
        REG_WORD:   rd_data <= ipb_data_t'(word_reg);  // zero extended
        REG_STATUS: rd_data <= ipb_data_t'(busy);
        default:    rd_data <= '0;
      endcase
    end
  end

endmodule

// ==== hw/slow_ctrl_top.sv ====
//////////////////////////////////////////////////
// slow control ipbus slave top
//////////////////////////////////////////////////
`timescale 1ns/10ps

module slow_ctrl_top import slow_ctrl_pkg::*; #(
  parameter int N_CHAN   = 5,                     // channel register blocks
  parameter int SCLK_DIV = 4                      // serial clock divider
) (
  input  logic              ipb_clk,
  input  logic              arst_n,
  input  logic              ipb_strobe,
  input  ipb_addr_t         ipb_addr,
  input  logic              ipb_write,
  input  ipb_data_t         ipb_wdata,
  output ipb_data_t         ipb_rdata,
  output logic              ipb_ack,
  output logic [N_CHAN-1:0] readout_pause,         // one per channel
  output logic              adcclk_dclk,           // clock synth serial port
  output logic              adcclk_ddat,
  output logic              adcclk_dlen,
  output logic              afe_dac_sclk,          // afe dac serial port
  output logic              afe_dac_sdi,
  output logic              afe_dac_sync_n
);

  logic                   io_sync, io_rd_en, io_wr_en, io_rd_ack;
  logic [N_CHAN+1:0]      io_sel;                  // one per peer
  ipb_data_t [N_CHAN-1:0] chan_rd_data;
  logic [N_CHAN-1:0]      chan_rd_ack;
  ipb_data_t              synth_rd_data, dac_rd_data;
  logic                   synth_rd_ack, dac_rd_ack;

  ////////////////////////////////////////////////
  // bus handshake and arbitration
  ipb_io_fsm ipb_io_fsm (
    .ipb_clk(ipb_clk), .arst_n(arst_n),
    .ipb_strobe(ipb_strobe), .ipb_write(ipb_write),
    .io_rd_ack(io_rd_ack),
    .io_sync(io_sync), .io_rd_en(io_rd_en), .io_wr_en(io_wr_en),
    .ipb_ack(ipb_ack)
  );

  slave_bus_arbiter #(.N_CHAN(N_CHAN)) slave_bus_arbiter (
    .ipb_clk(ipb_clk), .arst_n(arst_n),
    .slave_sel(ipb_addr[SEL_MSB:SEL_LSB]),         // top nibble only
    .io_sync(io_sync), .io_rd_en(io_rd_en), .io_sel(io_sel),
    .chan_rd_data(chan_rd_data), .chan_rd_ack(chan_rd_ack),
    .synth_rd_data(synth_rd_data), .dac_rd_data(dac_rd_data),
    .synth_rd_ack(synth_rd_ack), .dac_rd_ack(dac_rd_ack),
    .io_rd_ack(io_rd_ack), .ipb_rdata(ipb_rdata)
  );

  ////////////////////////////////////////////////
  // channel register blocks
  for (genvar k = 0; k < N_CHAN; k++) begin : g_chan
    chan_regs #(.CHAN_ID(k)) chan (
      .ipb_clk(ipb_clk), .arst_n(arst_n),
      .io_sel(io_sel[k]), .io_sync(io_sync),
      .io_rd_en(io_rd_en), .io_wr_en(io_wr_en),
      .reg_idx(ipb_addr[IDX_MSB:IDX_LSB]), .wr_data(ipb_wdata),
      .rd_data(chan_rd_data[k]), .rd_ack(chan_rd_ack[k]),
      .readout_pause(readout_pause[k])
    );
  end

  ////////////////////////////////////////////////
  // serial programming ports
  serial_prog_port #(
    .word_t(synth_word_t), .SCLK_DIV(SCLK_DIV), .FRAME_ACTIVE_LOW(1'b0)
  ) clock_synth (
    .ipb_clk(ipb_clk), .arst_n(arst_n),
    .io_sel(io_sel[N_CHAN]), .io_sync(io_sync),
    .io_rd_en(io_rd_en), .io_wr_en(io_wr_en),
    .reg_idx(ipb_addr[IDX_MSB:IDX_LSB]), .wr_data(ipb_wdata),
    .rd_data(synth_rd_data), .rd_ack(synth_rd_ack),
    .sclk(adcclk_dclk), .sdo(adcclk_ddat), .frame(adcclk_dlen)  // dlen high while shifting
  );

  serial_prog_port #(
    .word_t(dac_word_t), .SCLK_DIV(SCLK_DIV), .FRAME_ACTIVE_LOW(1'b1)
  ) afe_dac (
    .ipb_clk(ipb_clk), .arst_n(arst_n),
    .io_sel(io_sel[N_CHAN+1]), .io_sync(io_sync),
    .io_rd_en(io_rd_en), .io_wr_en(io_wr_en),
    .reg_idx(ipb_addr[IDX_MSB:IDX_LSB]), .wr_data(ipb_wdata),
    .rd_data(dac_rd_data), .rd_ack(dac_rd_ack),
    .sclk(afe_dac_sclk), .sdo(afe_dac_sdi), .frame(afe_dac_sync_n)  // sync_n low while shifting
  );

endmodule

// ==== tb/tb_slow_ctrl.sv ====
//////////////////////////////////////////////////
// slow control testbench
//////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_slow_ctrl import slow_ctrl_pkg::*; ();

  localparam int N_CHAN      = 5;
  localparam int SCLK_DIV    = 4;
  localparam int CLK_PERIOD  = 8;                   // ns
  localparam int MAX_VEC     = 64;
  localparam int ACK_TIMEOUT = 32;                  // cycles to wait for ipb_ack
  localparam int SHIFT_MAX   = 2 * SCLK_DIV * 32;   // longest serial frame in cycles

  logic              ipb_clk, arst_n, ipb_strobe, ipb_write, ipb_ack;
  ipb_addr_t         ipb_addr;
  ipb_data_t         ipb_wdata, ipb_rdata;
  logic [N_CHAN-1:0] readout_pause;
  logic              adcclk_dclk, adcclk_ddat, adcclk_dlen;
  logic              afe_dac_sclk, afe_dac_sdi, afe_dac_sync_n;

  logic [31:0] vec_mem [0:4*MAX_VEC-1];  // op, addr, data, expected per vector
  int          n_vec, pass_cnt, fail_cnt;
  bit          vec_ready, test_err;
  ipb_data_t   rd_word;                   // ipb_rdata seen with the last ack
  logic [31:0] synth_cap, dac_cap;        // rebuilt serial words
  int          synth_bits, dac_bits, synth_starts, dac_starts, synth_ends, dac_ends;

  slow_ctrl_top #(.N_CHAN(N_CHAN), .SCLK_DIV(SCLK_DIV)) dut (
    .ipb_clk(ipb_clk), .arst_n(arst_n),
    .ipb_strobe(ipb_strobe), .ipb_addr(ipb_addr),
    .ipb_write(ipb_write), .ipb_wdata(ipb_wdata),
    .ipb_rdata(ipb_rdata), .ipb_ack(ipb_ack),
    .readout_pause(readout_pause),
    .adcclk_dclk(adcclk_dclk), .adcclk_ddat(adcclk_ddat), .adcclk_dlen(adcclk_dlen),
    .afe_dac_sclk(afe_dac_sclk), .afe_dac_sdi(afe_dac_sdi), .afe_dac_sync_n(afe_dac_sync_n)
  );

  initial begin
    ipb_clk = 1'b0;
    forever #(CLK_PERIOD/2) ipb_clk = ~ipb_clk;    // 125 MHz
  end

  //////////////////////////////////////////////////
  // serial capture on rising sclk inside the frame
  always @(posedge adcclk_dlen) begin             // synth frame opens
    synth_cap  = '0;
    synth_bits = 0;
    synth_starts++;
  end
  always @(negedge adcclk_dlen) synth_ends++;
  always @(posedge adcclk_dclk) begin
    if (adcclk_dlen) begin
      synth_cap = {synth_cap[30:0], adcclk_ddat}; // msb first
      synth_bits++;
    end
  end

  always @(negedge afe_dac_sync_n) begin          // dac frame opens
    dac_cap  = '0;
    dac_bits = 0;
    dac_starts++;
  end
  always @(posedge afe_dac_sync_n) dac_ends++;
  always @(posedge afe_dac_sclk) begin
    if (!afe_dac_sync_n) begin
      dac_cap = {dac_cap[30:0], afe_dac_sdi};
      dac_bits++;
    end
  end

  function automatic int frame_starts_seen(input bit synth);
    return synth ? synth_starts : dac_starts;
  endfunction

  function automatic int frame_ends_seen(input bit synth);
    return synth ? synth_ends : dac_ends;
  endfunction

  //////////////////////////////////////////////////
  // bus tasks called on a falling edge
  task automatic bus_cycle(input logic wr, input ipb_addr_t addr, input ipb_data_t data,
                           output int lat);
    int n;
    n          = 0;
    lat        = -1;
    ipb_addr   = addr;
    ipb_write  = wr;
    ipb_wdata  = data;
    ipb_strobe = 1'b1;
    while (lat < 0 && n < ACK_TIMEOUT) begin
      @(negedge ipb_clk);
      n++;
      if (ipb_ack) lat = n - 1;                   // edge 0 saw the strobe
    end
    ipb_strobe = 1'b0;
    rd_word    = ipb_rdata;
    repeat (2 + $urandom % 4) @(negedge ipb_clk); // fsm needs 2 edges to release
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR %s %s expected %h actual %h", name, what, exp, act);
      test_err = 1'b1;
    end
  endtask

  task automatic flag_failure(input string msg);
    $display("%0d ns: %s", $time, msg);
    test_err = 1'b1;
  endtask

  task automatic do_write(input string name, input ipb_addr_t addr, input ipb_data_t data);
    int lat;
    bus_cycle(1'b1, addr, data, lat);
    if (lat < 0) flag_failure({name, " write was never acknowledged"});
    else check_value(name, "write ack edge", 32'd2, lat);
  endtask

  task automatic do_read(input string name, input ipb_addr_t addr, input logic [31:0] exp);
    int lat;
    bus_cycle(1'b0, addr, '0, lat);
    if (lat < 0) begin
      flag_failure({name, " read was never acknowledged"});
    end else begin
      check_value(name, "read ack edge", 32'd3, lat);
      check_value(name, "read data", exp, rd_word);
    end
  endtask

  // word, busy status, ignored second word, captured frame
  task automatic serial_test(input string name, input ipb_addr_t addr,
                             input ipb_data_t data, input logic [31:0] exp);
    bit        synth;
    int        width, starts0, ends0, n;
    ipb_addr_t status_addr;
    synth       = (addr[SEL_MSB:SEL_LSB] == SEL_CLK_SYNTH);
    width       = synth ? 32 : 24;
    status_addr = {addr[23:4], REG_STATUS};
    starts0     = frame_starts_seen(synth);
    ends0       = frame_ends_seen(synth);
    n           = 0;
    do_write(name, addr, data);
    do_read(name, status_addr, 32'd1);            // busy while shifting
    do_write(name, addr, ~data);                  // must be dropped
    while (frame_ends_seen(synth) == ends0 && n < SHIFT_MAX + 64) begin
      @(negedge ipb_clk);
      n++;
    end
    if (frame_ends_seen(synth) == ends0) begin
      flag_failure({name, " serial frame never completed"});
    end else begin
      check_value(name, "serial bit count", width, synth ? synth_bits : dac_bits);
      check_value(name, "serial word", exp, synth ? synth_cap : dac_cap);
    end
    do_read(name, status_addr, 32'd0);
    repeat (4 * SCLK_DIV) @(negedge ipb_clk);
    if (frame_starts_seen(synth) != starts0 + 1)
      flag_failure({name, " expected exactly one serial frame, the busy write was not dropped"});
  endtask

  //////////////////////////////////////////////////
  // main sequence
  initial begin
    int          op;
    string       name;
    ipb_addr_t   addr;
    ipb_data_t   data;
    logic [31:0] exp;
    void'($urandom(32'he0fb));                    // fixed seed for idle gaps
    arst_n     = 1'b0;
    ipb_strobe = 1'b0;
    ipb_write  = 1'b0;
    ipb_addr   = '0;
    ipb_wdata  = '0;
    $readmemh("tb/slow_ctrl_vectors.txt", vec_mem);
    n_vec = 0;
    while (n_vec < MAX_VEC && vec_mem[4*n_vec] !== 'x) n_vec++;
    vec_ready = 1'b1;
    if (n_vec == 0) begin
      $display("no test vectors could be read from tb/slow_ctrl_vectors.txt");
      fail_cnt++;
    end
    repeat (4) @(posedge ipb_clk);
    @(negedge ipb_clk);
    arst_n       = 1'b1;
    synth_starts = 0;                             // drop events from reset
    synth_ends   = 0;
    dac_starts   = 0;
    dac_ends     = 0;
    repeat (2) @(negedge ipb_clk);
    for (int i = 0; i < n_vec; i++) begin
      test_err = 1'b0;
      op       = vec_mem[4*i];
      addr     = vec_mem[4*i+1][23:0];
      data     = vec_mem[4*i+2];
      exp      = vec_mem[4*i+3];
      name     = $sformatf("vec%0d", i);
      case (op)
        0: do_write(name, addr, data);
        1: do_read(name, addr, exp);
        2: serial_test(name, addr, data, exp);
        3: check_value(name, "readout_pause", exp, 32'(readout_pause));
        default: flag_failure($sformatf("%s has unknown operation code %0d", name, op));
      endcase
      if (test_err) fail_cnt++;
      else pass_cnt++;
      $display("%s op %0d addr %h : %s", name, op, addr, test_err ? "FAIL" : "ok");
    end
    $display("summary: %0d tests ok, %0d tests with errors", pass_cnt, fail_cnt);
    if (fail_cnt == 0) $display("Testbench passed");
    else $display("Testbench failed");
    $finish;
  end

  // watchdog allows one longest shift plus margin per vector
  initial begin
    wait (vec_ready);
    repeat ((n_vec + 1) * (SHIFT_MAX + 128) + 16) @(posedge ipb_clk);
    $display("watchdog expired before all vectors were run");
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== tb/slow_ctrl_vectors.txt ====
// op addr data expected, all hex
// op 0 write, 1 read and compare, 2 serial shift and compare, 3 readout_pause compare
0 000001 12345678 00000000
1 0ab001 00000000 12345678
0 100001 cafef00d 00000000
1 100001 00000000 cafef00d
0 200001 0badbeef 00000000
1 200001 00000000 0badbeef
0 300001 a5a5c3c3 00000000
1 300001 00000000 a5a5c3c3
0 400001 deadface 00000000
1 400001 00000000 deadface
1 300002 00000000 00000003
0 400002 ffffffff 00000000
1 400002 00000000 00000004
0 200000 00000001 00000000
0 400000 ffffffff 00000000
3 000000 00000000 00000014
0 200000 fffffffe 00000000
3 000000 00000000 00000010
2 500000 c3a51e69 c3a51e69
1 500000 00000000 c3a51e69
2 600000 5ab2d4e1 00b2d4e1
1 600000 00000000 00b2d4e1
1 7f0000 00000000 00000000
1 f12345 00000000 00000000

// ==== all.f ====
hw/slow_ctrl_pkg.sv
hw/ipb_io_fsm.sv
hw/slave_bus_arbiter.sv
hw/chan_regs.sv
hw/serial_prog_port.sv
hw/slow_ctrl_top.sv
tb/tb_slow_ctrl.sv
